// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= l2_tb
FILELIST  ?= src.f

.PHONY: sim clean

# the run passes only when the pass line shows up in the simulator output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== logic/l2_fsm.sv ====
`timescale 1ns/10ps

module l2_fsm (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         do_rsp_next_i,
    input  logic                         do_cpu_req_next_i,
    input  l2_pkg::line_addr_t           cur_addr_i,
    input  l2_pkg::hprot_t               cur_hprot_i,
    input  l2_pkg::coh_msg_t             cur_coh_msg_i,
    input  l2_pkg::line_t                cur_line_i,
    input  logic [l2_pkg::REQS_BITS-1:0] reqs_i_i,
    input  logic                         reqs_hit_i,
    input  l2_pkg::unstable_state_t      reqs_state_i,
    input  l2_pkg::l2_way_t              reqs_way_i,
    input  l2_pkg::hprot_t               reqs_hprot_i,
    input  logic                         hit_i,
    input  l2_pkg::l2_way_t              hit_way_i,
    input  l2_pkg::line_t                hit_line_i,
    input  l2_pkg::l2_way_t              victim_way_i,
    input  logic                         l2_rd_rsp_ready_i,
    input  logic                         l2_req_out_ready_i,
    output logic                         decode_en_o,
    output logic                         wr_rst_o,
    output logic                         wr_en_o,
    output l2_pkg::l2_set_t              set_in_o,
    output l2_pkg::l2_way_t              way_o,
    output l2_pkg::l2_tag_t              wr_data_tag_o,
    output l2_pkg::state_t               wr_data_state_o,
    output l2_pkg::hprot_t               wr_data_hprot_o,
    output l2_pkg::line_t                wr_data_line_o,
    output l2_pkg::reqs_op_t             reqs_op_code_o,
    output logic [l2_pkg::REQS_BITS-1:0] reqs_i_wr_o,
    output l2_pkg::unstable_state_t      state_wr_data_req_o,
    output logic                         wr_en_put_reqs_o,
    output logic                         incr_reqs_cnt_o,
    output logic                         l2_rd_rsp_valid_o,
    output l2_pkg::line_t                l2_rd_rsp_line_o,
    output logic                         l2_req_out_valid_o,
    output l2_pkg::coh_msg_t             l2_req_out_coh_msg_o,
    output l2_pkg::line_addr_t           l2_req_out_addr_o
);

    l2_pkg::fsm_state_t state, next_state;
    l2_pkg::l2_set_t    rst_set;
    logic               fill;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= l2_pkg::RESET;
        end else begin
            state <= next_state;
        end
    end

    // one set is cleared per cycle while in RESET
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_set <= '0;
        end else if (state == l2_pkg::RESET) begin
            rst_set <= rst_set + 1'b1;
        end
    end

    assign decode_en_o = (state == l2_pkg::DECODE);

    // edata always fills, plain data only completes an ISD entry
    assign fill = reqs_hit_i && ((cur_coh_msg_i == l2_pkg::RSP_EDATA)
        || (cur_coh_msg_i == l2_pkg::RSP_DATA && reqs_state_i == l2_pkg::ISD));

    always_comb begin
        next_state = state;
        case (state)
            l2_pkg::RESET: begin
                if (rst_set == l2_pkg::l2_set_t'(l2_pkg::L2_SETS - 1)) begin
                    next_state = l2_pkg::DECODE;
                end
            end
            l2_pkg::DECODE: begin
                if (do_rsp_next_i) begin
                    next_state = l2_pkg::RSP_LOOKUP;
                end else if (do_cpu_req_next_i) begin
                    next_state = l2_pkg::CPU_REQ;
                end
            end
            l2_pkg::RSP_LOOKUP: begin
                next_state = fill ? l2_pkg::RSP_SEND_RD_RSP : l2_pkg::DECODE; // unmatched is dropped
            end
            l2_pkg::CPU_REQ: begin
                next_state = hit_i ? l2_pkg::CPU_HIT_RSP : l2_pkg::CPU_MISS_REQ;
            end
            l2_pkg::RSP_SEND_RD_RSP, l2_pkg::CPU_HIT_RSP: begin
                if (l2_rd_rsp_ready_i) begin
                    next_state = l2_pkg::DECODE;
                end
            end
            l2_pkg::CPU_MISS_REQ: begin
                if (l2_req_out_ready_i) begin
                    next_state = l2_pkg::DECODE;
                end
            end
            default: next_state = l2_pkg::RESET;
        endcase
    end

    // tag and set always come from the latched address outside of RESET
    assign wr_data_tag_o        = cur_addr_i[l2_pkg::LINE_ADDR_BITS-1 -: l2_pkg::TAG_BITS];
    assign l2_req_out_addr_o    = cur_addr_i;
    assign l2_req_out_coh_msg_o = l2_pkg::REQ_GETS;

    always_comb begin
        wr_rst_o            = 1'b0;
        wr_en_o             = 1'b0;
        set_in_o            = cur_addr_i[l2_pkg::SET_BITS-1:0];
        way_o               = '0;
        wr_data_state_o     = l2_pkg::INVALID;
        wr_data_hprot_o     = '0;
        wr_data_line_o      = cur_line_i;
        reqs_op_code_o      = l2_pkg::L2_REQS_IDLE;
        reqs_i_wr_o         = reqs_i_i;
        state_wr_data_req_o = l2_pkg::REQ_INVALID;
        wr_en_put_reqs_o    = 1'b0;
        incr_reqs_cnt_o     = 1'b0;
        l2_rd_rsp_valid_o   = 1'b0;
        l2_rd_rsp_line_o    = cur_line_i;
        l2_req_out_valid_o  = 1'b0;
        case (state)
            l2_pkg::RESET: begin
                wr_rst_o = 1'b1;
                set_in_o = rst_set;
            end
            l2_pkg::RSP_LOOKUP: begin
                reqs_op_code_o = l2_pkg::L2_REQS_LOOKUP;
            end
            l2_pkg::RSP_SEND_RD_RSP: begin
                l2_rd_rsp_valid_o = 1'b1;
                way_o             = reqs_way_i;
                wr_data_hprot_o   = reqs_hprot_i;
                wr_data_state_o   = (cur_coh_msg_i == l2_pkg::RSP_EDATA) ?
                                    l2_pkg::EXCLUSIVE : l2_pkg::SHARED;
                // line write and entry free only on the handshake edge
                if (l2_rd_rsp_ready_i) begin
                    wr_en_o          = 1'b1;
                    reqs_op_code_o   = l2_pkg::L2_REQS_PUT;
                    wr_en_put_reqs_o = 1'b1;
                    incr_reqs_cnt_o  = 1'b1;
                end
            end
            l2_pkg::CPU_HIT_RSP: begin
                l2_rd_rsp_valid_o = 1'b1;
                l2_rd_rsp_line_o  = hit_line_i;
                way_o             = hit_way_i;
            end
            l2_pkg::CPU_MISS_REQ: begin
                l2_req_out_valid_o  = 1'b1;
                state_wr_data_req_o = l2_pkg::ISD;
                way_o               = victim_way_i;
                wr_data_hprot_o     = cur_hprot_i;
                if (l2_req_out_ready_i) begin
                    reqs_op_code_o = l2_pkg::L2_REQS_ALLOC;
                end
            end
            default: begin
                reqs_op_code_o = l2_pkg::L2_REQS_IDLE;
            end
        endcase
    end

endmodule

// ==== logic/l2_input_arb.sv ====
`timescale 1ns/10ps

module l2_input_arb (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 decode_en_i,
    input  logic                 reqs_full_i,
    input  logic                 cpu_req_valid_i,
    input  l2_pkg::addr_t        cpu_req_addr_i,
    input  l2_pkg::hprot_t       cpu_req_hprot_i,
    input  logic                 rsp_in_valid_i,
    input  l2_pkg::coh_msg_t     rsp_in_coh_msg_i,
    input  l2_pkg::line_addr_t   rsp_in_addr_i,
    input  l2_pkg::line_t        rsp_in_line_i,
    output logic                 cpu_req_ready_o,
    output logic                 rsp_in_ready_o,
    output logic                 do_rsp_next_o,
    output logic                 do_cpu_req_next_o,
    output l2_pkg::line_addr_t   cur_addr_o,
    output l2_pkg::hprot_t       cur_hprot_o,
    output l2_pkg::coh_msg_t     cur_coh_msg_o,
    output l2_pkg::line_t        cur_line_o
);

    // responses always win, a cpu read also needs a free buffer entry
    assign rsp_in_ready_o  = decode_en_i;
    assign cpu_req_ready_o = decode_en_i && !rsp_in_valid_i && !reqs_full_i;

    assign do_rsp_next_o     = rsp_in_valid_i && rsp_in_ready_o;
    assign do_cpu_req_next_o = cpu_req_valid_i && cpu_req_ready_o;

    always_ff @(posedge clk) begin
        if (do_rsp_next_o) begin
            cur_addr_o    <= rsp_in_addr_i;
            cur_coh_msg_o <= rsp_in_coh_msg_i;
            cur_line_o    <= rsp_in_line_i;
        end else if (do_cpu_req_next_o) begin
            cur_addr_o <= cpu_req_addr_i[l2_pkg::ADDR_BITS-1:l2_pkg::OFFSET_BITS];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cur_hprot_o <= 1'b0;
        end else if (do_cpu_req_next_o) begin
            cur_hprot_o <= cpu_req_hprot_i;
        end
    end

endmodule

// ==== logic/l2_pkg.sv ====
package l2_pkg;

    localparam int ADDR_BITS      = 32;
    localparam int OFFSET_BITS    = 4;   // 16-byte lines
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;
    localparam int SET_BITS       = 4;
    localparam int L2_SETS        = 16;
    localparam int TAG_BITS       = 24;
    localparam int L2_WAYS        = 2;
    localparam int WAY_BITS       = 1;
    localparam int N_REQS         = 4;
    localparam int REQS_BITS      = 2;
    localparam int LINE_BITS      = 128; // four 32-bit words

    typedef logic [ADDR_BITS-1:0]      addr_t;
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [SET_BITS-1:0]       l2_set_t;
    typedef logic [TAG_BITS-1:0]       l2_tag_t;
    typedef logic [WAY_BITS-1:0]       l2_way_t;
    typedef logic [LINE_BITS-1:0]      line_t;
    typedef logic                      hprot_t;

    // stable states kept in the tag memory
    typedef enum logic [1:0] {
        INVALID   = 2'b00,
        SHARED    = 2'b01,
        EXCLUSIVE = 2'b10
    } state_t;

    // transient states of a request-buffer entry
    typedef enum logic [1:0] {
        REQ_INVALID = 2'b00,
        ISD         = 2'b01
    } unstable_state_t;

    typedef enum logic [1:0] {
        REQ_GETS  = 2'b00,
        RSP_DATA  = 2'b01,
        RSP_EDATA = 2'b10
    } coh_msg_t;

    typedef enum logic [1:0] {
        L2_REQS_IDLE   = 2'b00,
        L2_REQS_LOOKUP = 2'b01,
        L2_REQS_ALLOC  = 2'b10,
        L2_REQS_PUT    = 2'b11
    } reqs_op_t;

    typedef enum logic [2:0] {
        RESET           = 3'd0,
        DECODE          = 3'd1,
        RSP_LOOKUP      = 3'd2,
        RSP_SEND_RD_RSP = 3'd3,
        CPU_REQ         = 3'd4,
        CPU_HIT_RSP     = 3'd5,
        CPU_MISS_REQ    = 3'd6
    } fsm_state_t;

endpackage

// ==== logic/l2_reqs_buf.sv ====
`timescale 1ns/10ps

module l2_reqs_buf (
    input  logic                     clk,
    input  logic                     rst,
    input  l2_pkg::reqs_op_t         reqs_op_code_i,
    input  l2_pkg::line_addr_t       lookup_addr_i,
    input  logic                     wr_en_put_reqs_i,
    input  logic [l2_pkg::REQS_BITS-1:0] reqs_i_wr_i,
    input  l2_pkg::unstable_state_t  state_wr_data_req_i,
    input  l2_pkg::l2_way_t          wr_way_i,
    input  l2_pkg::hprot_t           wr_hprot_i,
    input  logic                     incr_reqs_cnt_i,
    output logic [l2_pkg::REQS_BITS-1:0] reqs_i_o,
    output logic                     reqs_hit_o,
    output l2_pkg::unstable_state_t  reqs_state_o,
    output l2_pkg::l2_way_t          reqs_way_o,
    output l2_pkg::hprot_t           reqs_hprot_o,
    output logic                     reqs_full_o
);

    l2_pkg::line_addr_t      addr  [l2_pkg::N_REQS];
    l2_pkg::unstable_state_t state [l2_pkg::N_REQS];
    l2_pkg::l2_way_t         way   [l2_pkg::N_REQS];
    l2_pkg::hprot_t          hprot [l2_pkg::N_REQS];

    logic [l2_pkg::REQS_BITS:0]   free_cnt;
    logic [l2_pkg::REQS_BITS-1:0] match_i, free_i;
    logic                         match_found;

    // descending scan so the lowest index wins
    always_comb begin
        match_i     = '0;
        free_i      = '0;
        match_found = 1'b0;
        for (int i = l2_pkg::N_REQS - 1; i >= 0; i--) begin
            if (state[i] != l2_pkg::REQ_INVALID && addr[i] == lookup_addr_i) begin
                match_i     = l2_pkg::REQS_BITS'(i);
                match_found = 1'b1;
            end
            if (state[i] == l2_pkg::REQ_INVALID) begin
                free_i = l2_pkg::REQS_BITS'(i);
            end
        end
    end

    assign reqs_i_o     = (reqs_op_code_i == l2_pkg::L2_REQS_ALLOC) ? free_i : match_i;
    assign reqs_hit_o   = (reqs_op_code_i == l2_pkg::L2_REQS_LOOKUP) && match_found;
    assign reqs_state_o = state[match_i];
    assign reqs_way_o   = way[match_i];
    assign reqs_hprot_o = hprot[match_i];
    assign reqs_full_o  = (free_cnt == '0);

    logic alloc_en, put_en;
    assign alloc_en = (reqs_op_code_i == l2_pkg::L2_REQS_ALLOC);
    assign put_en   = (reqs_op_code_i == l2_pkg::L2_REQS_PUT) && wr_en_put_reqs_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < l2_pkg::N_REQS; i++) begin
                state[i] <= l2_pkg::REQ_INVALID;
            end
        end else if (alloc_en || put_en) begin
            state[reqs_i_wr_i] <= state_wr_data_req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            addr[reqs_i_wr_i]  <= lookup_addr_i;
            way[reqs_i_wr_i]   <= wr_way_i;
            hprot[reqs_i_wr_i] <= wr_hprot_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            free_cnt <= (l2_pkg::REQS_BITS+1)'(l2_pkg::N_REQS);
        end else if (alloc_en && !incr_reqs_cnt_i) begin
            free_cnt <= free_cnt - 1'b1;
        end else if (incr_reqs_cnt_i && !alloc_en) begin
            free_cnt <= free_cnt + 1'b1;
        end
    end

endmodule

// ==== logic/l2_tag_state_mem.sv ====
`timescale 1ns/10ps

module l2_tag_state_mem (
    input  logic             clk,
    input  logic             rst,
    input  l2_pkg::l2_set_t  set_in_i,
    input  l2_pkg::l2_tag_t  lookup_tag_i,
    input  logic             wr_rst_i,
    input  logic             wr_en_i,
    input  l2_pkg::l2_way_t  way_i,
    input  l2_pkg::l2_tag_t  wr_data_tag_i,
    input  l2_pkg::state_t   wr_data_state_i,
    input  l2_pkg::hprot_t   wr_data_hprot_i,
    input  l2_pkg::line_t    wr_data_line_i,
    output logic             hit_o,
    output l2_pkg::l2_way_t  hit_way_o,
    output l2_pkg::line_t    hit_line_o,
    output l2_pkg::l2_way_t  victim_way_o
);

    l2_pkg::l2_tag_t tags   [l2_pkg::L2_SETS][l2_pkg::L2_WAYS];
    l2_pkg::state_t  states [l2_pkg::L2_SETS][l2_pkg::L2_WAYS];
    l2_pkg::hprot_t  hprots [l2_pkg::L2_SETS][l2_pkg::L2_WAYS];
    l2_pkg::line_t   lines  [l2_pkg::L2_SETS][l2_pkg::L2_WAYS];
    l2_pkg::l2_way_t rr     [l2_pkg::L2_SETS];

    logic empty_found;

    always_comb begin
        hit_o        = 1'b0;
        hit_way_o    = '0;
        empty_found  = 1'b0;
        victim_way_o = rr[set_in_i]; // used only when the set is full
        for (int w = l2_pkg::L2_WAYS - 1; w >= 0; w--) begin
            if (states[set_in_i][w] != l2_pkg::INVALID && tags[set_in_i][w] == lookup_tag_i) begin
                hit_o     = 1'b1;
                hit_way_o = l2_pkg::WAY_BITS'(w);
            end
            if (states[set_in_i][w] == l2_pkg::INVALID) begin
                empty_found  = 1'b1;
                victim_way_o = l2_pkg::WAY_BITS'(w);
            end
        end
    end

    assign hit_line_o = lines[set_in_i][hit_way_o];

    always_ff @(posedge clk) begin
        if (wr_rst_i) begin
            for (int w = 0; w < l2_pkg::L2_WAYS; w++) begin
                states[set_in_i][w] <= l2_pkg::INVALID;
            end
        end else if (wr_en_i) begin
            tags[set_in_i][way_i]   <= wr_data_tag_i;
            states[set_in_i][way_i] <= wr_data_state_i;
            hprots[set_in_i][way_i] <= wr_data_hprot_i;
            lines[set_in_i][way_i]  <= wr_data_line_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < l2_pkg::L2_SETS; s++) begin
                rr[s] <= '0;
            end
        end else if (wr_en_i && !empty_found) begin
            rr[set_in_i] <= rr[set_in_i] + 1'b1;
        end
    end

endmodule

// ==== logic/l2_top.sv ====
`timescale 1ns/10ps

module l2_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_req_valid_i,
    input  l2_pkg::addr_t      cpu_req_addr_i,
    input  l2_pkg::hprot_t     cpu_req_hprot_i,
    output logic               cpu_req_ready_o,
    input  logic               rsp_in_valid_i,
    input  l2_pkg::coh_msg_t   rsp_in_coh_msg_i,
    input  l2_pkg::line_addr_t rsp_in_addr_i,
    input  l2_pkg::line_t      rsp_in_line_i,
    output logic               rsp_in_ready_o,
    output logic               rd_rsp_valid_o,
    output l2_pkg::line_t      rd_rsp_line_o,
    input  logic               rd_rsp_ready_i,
    output logic               req_out_valid_o,
    output l2_pkg::coh_msg_t   req_out_coh_msg_o,
    output l2_pkg::line_addr_t req_out_addr_o,
    input  logic               req_out_ready_i
);

    logic                         decode_en, reqs_full, do_rsp_next, do_cpu_req_next;
    l2_pkg::line_addr_t           cur_addr;
    l2_pkg::hprot_t               cur_hprot, reqs_hprot, wr_data_hprot;
    l2_pkg::coh_msg_t             cur_coh_msg;
    l2_pkg::line_t                cur_line, hit_line, wr_data_line;
    logic [l2_pkg::REQS_BITS-1:0] reqs_i, reqs_i_wr;
    logic                         reqs_hit, wr_en_put_reqs, incr_reqs_cnt;
    l2_pkg::unstable_state_t      reqs_state, state_wr_data_req;
    l2_pkg::l2_way_t              reqs_way, hit_way, victim_way, way;
    l2_pkg::reqs_op_t             reqs_op_code;
    logic                         hit, wr_rst, wr_en;
    l2_pkg::l2_set_t              set_in;
    l2_pkg::l2_tag_t              wr_data_tag;
    l2_pkg::state_t               wr_data_state;

    l2_input_arb u_arb (
        .clk(clk), .rst(rst), .decode_en_i(decode_en), .reqs_full_i(reqs_full),
        .cpu_req_valid_i(cpu_req_valid_i), .cpu_req_addr_i(cpu_req_addr_i),
        .cpu_req_hprot_i(cpu_req_hprot_i), .rsp_in_valid_i(rsp_in_valid_i),
        .rsp_in_coh_msg_i(rsp_in_coh_msg_i), .rsp_in_addr_i(rsp_in_addr_i),
        .rsp_in_line_i(rsp_in_line_i), .cpu_req_ready_o(cpu_req_ready_o),
        .rsp_in_ready_o(rsp_in_ready_o), .do_rsp_next_o(do_rsp_next),
        .do_cpu_req_next_o(do_cpu_req_next), .cur_addr_o(cur_addr),
        .cur_hprot_o(cur_hprot), .cur_coh_msg_o(cur_coh_msg), .cur_line_o(cur_line)
    );

    l2_reqs_buf u_reqs_buf (
        .clk(clk), .rst(rst), .reqs_op_code_i(reqs_op_code), .lookup_addr_i(cur_addr),
        .wr_en_put_reqs_i(wr_en_put_reqs), .reqs_i_wr_i(reqs_i_wr),
        .state_wr_data_req_i(state_wr_data_req), .wr_way_i(way),
        .wr_hprot_i(wr_data_hprot), .incr_reqs_cnt_i(incr_reqs_cnt),
        .reqs_i_o(reqs_i), .reqs_hit_o(reqs_hit), .reqs_state_o(reqs_state),
        .reqs_way_o(reqs_way), .reqs_hprot_o(reqs_hprot), .reqs_full_o(reqs_full)
    );

    l2_tag_state_mem u_mem (
        .clk(clk), .rst(rst), .set_in_i(set_in), .lookup_tag_i(wr_data_tag),
        .wr_rst_i(wr_rst), .wr_en_i(wr_en), .way_i(way), .wr_data_tag_i(wr_data_tag),
        .wr_data_state_i(wr_data_state), .wr_data_hprot_i(wr_data_hprot),
        .wr_data_line_i(wr_data_line), .hit_o(hit), .hit_way_o(hit_way),
        .hit_line_o(hit_line), .victim_way_o(victim_way)
    );

    l2_fsm u_fsm (
        .clk(clk), .rst(rst), .do_rsp_next_i(do_rsp_next),
        .do_cpu_req_next_i(do_cpu_req_next), .cur_addr_i(cur_addr),
        .cur_hprot_i(cur_hprot), .cur_coh_msg_i(cur_coh_msg), .cur_line_i(cur_line),
        .reqs_i_i(reqs_i), .reqs_hit_i(reqs_hit), .reqs_state_i(reqs_state),
        .reqs_way_i(reqs_way), .reqs_hprot_i(reqs_hprot), .hit_i(hit),
        .hit_way_i(hit_way), .hit_line_i(hit_line), .victim_way_i(victim_way),
        .l2_rd_rsp_ready_i(rd_rsp_ready_i), .l2_req_out_ready_i(req_out_ready_i),
        .decode_en_o(decode_en), .wr_rst_o(wr_rst), .wr_en_o(wr_en),
        .set_in_o(set_in), .way_o(way), .wr_data_tag_o(wr_data_tag),
        .wr_data_state_o(wr_data_state), .wr_data_hprot_o(wr_data_hprot),
        .wr_data_line_o(wr_data_line), .reqs_op_code_o(reqs_op_code),
        .reqs_i_wr_o(reqs_i_wr), .state_wr_data_req_o(state_wr_data_req),
        .wr_en_put_reqs_o(wr_en_put_reqs), .incr_reqs_cnt_o(incr_reqs_cnt),
        .l2_rd_rsp_valid_o(rd_rsp_valid_o), .l2_rd_rsp_line_o(rd_rsp_line_o),
        .l2_req_out_valid_o(req_out_valid_o), .l2_req_out_coh_msg_o(req_out_coh_msg_o),
        .l2_req_out_addr_o(req_out_addr_o)
    );

endmodule

// ==== src.f ====
logic/l2_pkg.sv
logic/l2_input_arb.sv
logic/l2_reqs_buf.sv
logic/l2_tag_state_mem.sv
logic/l2_fsm.sv
logic/l2_top.sv
tb/l2_tb.sv

// ==== tb/l2_tb.sv ====
`timescale 1ns/10ps

module l2_tb;

    localparam int TIMEOUT_CYCLES = 100;
    localparam int BLOCK_CYCLES   = 20;

    localparam l2_pkg::line_t LINE_A = 128'h0a0a_1111_2222_3333_4444_5555_6666_7777;
    localparam l2_pkg::line_t LINE_B = 128'h0b0b_89ab_cdef_0123_4567_fedc_ba98_7654;
    localparam l2_pkg::line_t LINE_C = 128'h0c0c_dead_beef_cafe_f00d_1234_5678_9abc;
    localparam l2_pkg::line_t LINE_D = 128'h0d0d_a5a5_5a5a_0f0f_f0f0_3c3c_c3c3_9696;

    typedef enum {K_CPU, K_RSP, K_CPU_BLOCKED, K_CPU_HELD} op_kind_t;
    typedef enum {EXP_NONE, EXP_LINE, EXP_GETS} exp_kind_t;

    typedef struct {
        string            name;
        op_kind_t         kind;
        l2_pkg::addr_t    addr;
        l2_pkg::coh_msg_t msg;
        l2_pkg::line_t    line;
        exp_kind_t        exp;
    } row_t;

    logic               clk;
    logic               rst;
    logic               cpu_req_valid_i;
    l2_pkg::addr_t      cpu_req_addr_i;
    l2_pkg::hprot_t     cpu_req_hprot_i;
    logic               cpu_req_ready_o;
    logic               rsp_in_valid_i;
    l2_pkg::coh_msg_t   rsp_in_coh_msg_i;
    l2_pkg::line_addr_t rsp_in_addr_i;
    l2_pkg::line_t      rsp_in_line_i;
    logic               rsp_in_ready_o;
    logic               rd_rsp_valid_o;
    l2_pkg::line_t      rd_rsp_line_o;
    logic               rd_rsp_ready_i;
    logic               req_out_valid_o;
    l2_pkg::coh_msg_t   req_out_coh_msg_o;
    l2_pkg::line_addr_t req_out_addr_o;
    logic               req_out_ready_i;

    row_t               rows[$];
    l2_pkg::line_t      rd_lines[$];
    l2_pkg::line_addr_t req_addrs[$];
    l2_pkg::coh_msg_t   req_msgs[$];
    int                 errors = 0;
    bit                 timed_out = 1'b0;
    integer             seed = 15986;

    l2_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

    task automatic check_line(input l2_pkg::line_t got, input l2_pkg::line_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_addr(input l2_pkg::line_addr_t got, input l2_pkg::line_addr_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_msg(input l2_pkg::coh_msg_t got, input l2_pkg::coh_msg_t exp,
                             input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %0d got %0d", $time, what, exp, got);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("Fail at %0t: %s expected %0d got %0d", $time, what, exp, got);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    // random ready stalls, then sampling 1 ns after the falling edge
    initial begin
        bit            rd_hold;
        bit            rq_hold;
        l2_pkg::line_t held_line;
        l2_pkg::line_addr_t held_addr;
        rd_rsp_ready_i  = 1'b0;
        req_out_ready_i = 1'b0;
        rd_hold         = 1'b0;
        rq_hold         = 1'b0;
        forever begin
            @(negedge clk);
            rd_rsp_ready_i  = ($random(seed) & 3) != 0;
            req_out_ready_i = ($random(seed) & 3) != 0;
            #1;
            if (!rst && (rd_rsp_valid_o || req_out_valid_o)) begin
                errors++;
                $display("a valid output went high during reset at %0t", $time);
            end
            if (rd_hold) begin
                if (!rd_rsp_valid_o)
                    $display("rd_rsp valid dropped before its handshake at %0t", $time);
                errors += rd_rsp_valid_o ? 0 : 1;
                check_line(rd_rsp_line_o, held_line, "stalled rd_rsp line");
            end
            if (rq_hold) begin
                if (!req_out_valid_o)
                    $display("req_out valid dropped before its handshake at %0t", $time);
                errors += req_out_valid_o ? 0 : 1;
                check_addr(req_out_addr_o, held_addr, "stalled req_out address");
            end
            if (rd_rsp_valid_o && rd_rsp_ready_i)
                rd_lines.push_back(rd_rsp_line_o);
            if (req_out_valid_o && req_out_ready_i) begin
                req_addrs.push_back(req_out_addr_o);
                req_msgs.push_back(req_out_coh_msg_o);
            end
            rd_hold   = rd_rsp_valid_o && !rd_rsp_ready_i;
            rq_hold   = req_out_valid_o && !req_out_ready_i;
            held_line = rd_rsp_line_o;
            held_addr = req_out_addr_o;
        end
    end

    task automatic add_row(input string name, input op_kind_t kind, input l2_pkg::addr_t addr,
                           input l2_pkg::coh_msg_t msg, input l2_pkg::line_t line,
                           input exp_kind_t exp);
        row_t r;
        r.name = name;
        r.kind = kind;
        r.addr = addr;
        r.msg  = msg;
        r.line = line;
        r.exp  = exp;
        rows.push_back(r);
    endtask

    task automatic fill_table();
        add_row("cold miss from reset", K_CPU, 32'h0000_1230, l2_pkg::REQ_GETS, '0, EXP_GETS);
        add_row("edata fill", K_RSP, 32'h0000_1230, l2_pkg::RSP_EDATA, LINE_A, EXP_LINE);
        add_row("hit after edata", K_CPU, 32'h0000_1234, l2_pkg::REQ_GETS, LINE_A, EXP_LINE);
        add_row("second miss", K_CPU, 32'h0000_4450, l2_pkg::REQ_GETS, '0, EXP_GETS);
        add_row("data fill to isd", K_RSP, 32'h0000_4450, l2_pkg::RSP_DATA, LINE_B, EXP_LINE);
        add_row("hit after data", K_CPU, 32'h0000_4458, l2_pkg::REQ_GETS, LINE_B, EXP_LINE);
        add_row("unmatched rsp", K_RSP, 32'h0000_9990, l2_pkg::RSP_DATA, LINE_C, EXP_NONE);
        add_row("fill buffer 0", K_CPU, 32'ha000_0010, l2_pkg::REQ_GETS, '0, EXP_GETS);
        add_row("fill buffer 1", K_CPU, 32'ha000_0020, l2_pkg::REQ_GETS, '0, EXP_GETS);
        add_row("fill buffer 2", K_CPU, 32'ha000_0030, l2_pkg::REQ_GETS, '0, EXP_GETS);
        add_row("fill buffer 3", K_CPU, 32'ha000_0040, l2_pkg::REQ_GETS, '0, EXP_GETS);
        add_row("blocked when full", K_CPU_BLOCKED, 32'hb000_0060, l2_pkg::REQ_GETS, '0,
                EXP_NONE);
        add_row("free one entry", K_RSP, 32'ha000_0020, l2_pkg::RSP_EDATA, LINE_C, EXP_LINE);
        add_row("held request goes", K_CPU_HELD, 32'hb000_0060, l2_pkg::REQ_GETS, '0,
                EXP_GETS);
        add_row("fill entry 0", K_RSP, 32'ha000_0010, l2_pkg::RSP_DATA, LINE_D, EXP_LINE);
        add_row("hit on entry 0 line", K_CPU, 32'ha000_0018, l2_pkg::REQ_GETS, LINE_D, EXP_LINE);
        add_row("old line still hits", K_CPU, 32'h0000_123c, l2_pkg::REQ_GETS, LINE_A, EXP_LINE);
    endtask

    task automatic drive_cpu(input l2_pkg::addr_t a);
        @(negedge clk);
        cpu_req_valid_i = 1'b1;
        cpu_req_addr_i  = a;
        cpu_req_hprot_i = 1'b1;
        #1;
    endtask

    task automatic drive_rsp(input l2_pkg::coh_msg_t m, input l2_pkg::addr_t a,
                             input l2_pkg::line_t l);
        @(negedge clk);
        rsp_in_valid_i   = 1'b1;
        rsp_in_coh_msg_i = m;
        rsp_in_addr_i    = a[l2_pkg::ADDR_BITS-1:l2_pkg::OFFSET_BITS];
        rsp_in_line_i    = l;
        #1;
    endtask

    // starts and ends 1 ns after a falling edge, the transfer is on the edge in between
    task automatic wait_accept(input bit is_rsp);
        int n;
        n = 0;
        while (!(is_rsp ? rsp_in_ready_o : cpu_req_ready_o) && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!(is_rsp ? rsp_in_ready_o : cpu_req_ready_o)) begin
            report_timeout(is_rsp ? "the response to be accepted" : "the cpu request to be accepted");
        end else begin
            @(negedge clk);
            if (is_rsp)
                rsp_in_valid_i = 1'b0;
            else
                cpu_req_valid_i = 1'b0;
            #1;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (!rsp_in_ready_o && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!rsp_in_ready_o)
            report_timeout("the controller to return to decode");
    endtask

    task automatic watch_blocked();
        for (int n = 0; n < BLOCK_CYCLES; n++) begin
            if (cpu_req_ready_o) begin
                errors++;
                $display("cpu request was accepted at %0t with the buffer full", $time);
            end
            @(negedge clk);
            #1;
        end
    endtask

    task automatic run_row(input row_t r);
        case (r.kind)
            K_CPU: begin
                drive_cpu(r.addr);
                wait_accept(1'b0);
            end
            K_RSP: begin
                drive_rsp(r.msg, r.addr, r.line);
                wait_accept(1'b1);
            end
            K_CPU_BLOCKED: begin
                drive_cpu(r.addr);
                watch_blocked();
            end
            default: begin
                wait_accept(1'b0); // request has been held since the blocked row
            end
        endcase
        if (!timed_out && r.kind != K_CPU_BLOCKED)
            wait_idle();
    endtask

    task automatic check_result(input row_t r, input int rd0, input int rq0);
        check_count(rd_lines.size() - rd0, (r.exp == EXP_LINE) ? 1 : 0, "rd_rsp count");
        check_count(req_addrs.size() - rq0, (r.exp == EXP_GETS) ? 1 : 0, "req_out count");
        if (r.exp == EXP_LINE && rd_lines.size() > rd0)
            check_line(rd_lines[rd0], r.line, "rd_rsp line");
        if (r.exp == EXP_GETS && req_addrs.size() > rq0) begin
            check_addr(req_addrs[rq0], r.addr[l2_pkg::ADDR_BITS-1:l2_pkg::OFFSET_BITS],
                       "req_out address");
            check_msg(req_msgs[rq0], l2_pkg::REQ_GETS, "req_out message");
        end
    endtask

    initial begin
        int rd0;
        int rq0;
        int err0;
        int passed;
        int run;
        cpu_req_valid_i  = 1'b0;
        cpu_req_addr_i   = '0;
        cpu_req_hprot_i  = 1'b0;
        rsp_in_valid_i   = 1'b0;
        rsp_in_coh_msg_i = l2_pkg::RSP_DATA;
        rsp_in_addr_i    = '0;
        rsp_in_line_i    = '0;
        passed = 0;
        run    = 0;
        fill_table();
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            rd0  = rd_lines.size();
            rq0  = req_addrs.size();
            err0 = errors;
            run_row(rows[i]);
            if (!timed_out)
                check_result(rows[i], rd0, rq0);
            run++;
            passed += (errors == err0) ? 1 : 0;
            $display("test %0d %s: %s", i, rows[i].name, (errors == err0) ? "passed" : "failed");
        end
        $display("%0d of %0d tests run, %0d passed, %0d errors", run, rows.size(), passed, errors);
        if (errors == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
